/* filelist.f */
+incdir+rtl
rtl/exec_pkg.sv
rtl/instr_decoder.sv
rtl/register_file.sv
rtl/alu.sv
rtl/exec_core.sv
verif/clock_gen.sv
verif/exec_core_tb.sv

/* Makefile */
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -sv -f filelist.f --top-module exec_core_tb -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > $(LOG) 2>&1; cat $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verif/exec_core_tb.sv */
`default_nettype none

module exec_core_tb import exec_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		word_t instr;
		word_t result;
		logic  overflow;
		logic  illegal;
	} entry_t;

	logic  clk;
	logic  reset;
	logic  instr_valid;
	word_t instr;
	logic  result_valid;
	word_t result;
	logic  overflow;
	logic  illegal;

	entry_t entries [$];
	int value_errors = 0;
	int protocol_errors = 0;
	int cur_entry = -1;
	int cycle_count = 0;
	int timeout_cycles;

	clock_gen u_clk (.clk(clk));

	exec_core uut (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.result_valid (result_valid),
		.result       (result),
		.overflow     (overflow),
		.illegal      (illegal)
	);

	// immediate form: opcode, rt, ra and a 15-bit immediate.
	function automatic word_t encode_imm(input logic [5:0] op, input int rt, input int ra,
		input int imm);
		return {1'b0, op, rt[4:0], ra[4:0], imm[14:0]};
	endfunction

	// register form: opcode, rt, ra, rb and the sub-op in the low bits.
	function automatic word_t encode_reg(input logic [5:0] op, input int rt, input int ra,
		input int rb, input logic [4:0] sub);
		return {1'b0, op, rt[4:0], ra[4:0], rb[4:0], 5'b0, sub};
	endfunction

	task automatic add_entry(input word_t w, input word_t res, input logic ovf, input logic ill);
		entries.push_back('{instr: w, result: res, overflow: ovf, illegal: ill});
	endtask

	task automatic build_table();
		add_entry(encode_imm(ADDI, 1, 0, 'h0005), 32'h0000_0005, 1'b0, 1'b0);
		add_entry(encode_imm(ADDI, 2, 0, 'h7FFF), 32'hFFFF_FFFF, 1'b0, 1'b0);
		add_entry(encode_imm(ADDI, 3, 0, 'h4000), 32'hFFFF_C000, 1'b0, 1'b0);
		add_entry(encode_imm(ADDI, 4, 0, 'h3FFF), 32'h0000_3FFF, 1'b0, 1'b0);
		add_entry(encode_imm(ADDI, 5, 0, 'h0123), 32'h0000_0123, 1'b0, 1'b0);
		add_entry(encode_imm(ADDI, 0, 0, 'h0042), 32'h0000_0042, 1'b0, 1'b0); // no write to r0.
		add_entry(encode_reg(TY_BASE, 17, 20, 0, ADD), 32'h0000_0000, 1'b0, 1'b0); // r20 kept its reset value.
		add_entry(encode_reg(TY_BASE, 6, 0, 0, ADD), 32'h0000_0000, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 6, 1, 5, ADD), 32'h0000_0128, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 6, 5, 1, SUB), 32'h0000_011E, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 6, 4, 5, AND), 32'h0000_0123, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 6, 3, 1, OR), 32'hFFFF_C005, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 6, 2, 4, XOR), 32'hFFFF_C000, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 6, 2, 1, ADD), 32'h0000_0004, 1'b0, 1'b0);
		add_entry(encode_imm(ADDI, 7, 0, 'h0001), 32'h0000_0001, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 8, 7, 31, SLLI), 32'h8000_0000, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 9, 8, 7, SUB), 32'h7FFF_FFFF, 1'b1, 1'b0);
		add_entry(encode_reg(TY_BASE, 10, 9, 7, ADD), 32'h8000_0000, 1'b1, 1'b0);
		add_entry(encode_reg(TY_BASE, 11, 3, 1, SLT), 32'h0000_0000, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 11, 3, 1, SLTS), 32'h0000_0001, 1'b0, 1'b0);
		add_entry(encode_imm(ADDI, 12, 0, 'h0024), 32'h0000_0024, 1'b0, 1'b0); // shift of 36.
		add_entry(encode_reg(TY_BASE, 13, 5, 12, SLL), 32'h0000_1230, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 13, 3, 12, SRL), 32'h0FFF_FC00, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 13, 1, 3, SLLI), 32'h0000_0028, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 13, 8, 31, SRLI), 32'h0000_0001, 1'b0, 1'b0);
		add_entry(encode_imm(ADDI, 14, 0, 'h1234), 32'h0000_1234, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 14, 14, 16, SLLI), 32'h1234_0000, 1'b0, 1'b0);
		add_entry(encode_imm(ORI, 14, 14, 'h5678), 32'h1234_5678, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 15, 14, 8, ROTRI), 32'h7812_3456, 1'b0, 1'b0);
		add_entry(encode_imm(SUBRI, 16, 5, 'h0200), 32'h0000_00DD, 1'b0, 1'b0);
		add_entry(encode_imm(ANDI, 16, 2, 'h7FFF), 32'h0000_7FFF, 1'b0, 1'b0);
		add_entry(encode_imm(XORI, 16, 2, 'h4001), 32'hFFFF_BFFE, 1'b0, 1'b0);
		add_entry(encode_imm(LWI, 1, 5, 'h0010), 32'h0000_0133, 1'b0, 1'b0);
		add_entry(encode_imm(SWI, 2, 5, 'h7FF0), 32'h0000_0113, 1'b0, 1'b0);
		add_entry(encode_reg(TY_LS, 4, 1, 5, 5'd0), 32'h0000_0128, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 17, 1, 4, ADD), 32'h0000_4004, 1'b0, 1'b0);
		add_entry(encode_reg(TY_BASE, 17, 2, 2, ADD), 32'hFFFF_FFFE, 1'b0, 1'b0);
		add_entry(encode_imm(6'h3F, 1, 5, 'h0001), 32'h0000_0000, 1'b0, 1'b1);
		add_entry(encode_reg(TY_BASE, 1, 5, 5, 5'd5), 32'h0000_0000, 1'b0, 1'b1);
		add_entry(encode_reg(TY_BASE, 17, 1, 0, ADD), 32'h0000_0005, 1'b0, 1'b0);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h at entry %0d", name, got, exp, cur_entry);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Fail %s: got 0x%h, expected 0x%h at entry %0d", name, got, exp, cur_entry);
			value_errors++;
		end
	endtask

	task automatic check_entry(input int idx);
		cur_entry = idx;
		if (result_valid !== 1'b1) begin
			$display("no result_valid in the cycle after entry %0d was issued", idx);
			protocol_errors++;
		end else begin
			check_word("result", result, entries[idx].result);
			check_flag("overflow", overflow, entries[idx].overflow);
			check_flag("illegal", illegal, entries[idx].illegal);
		end
	endtask

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > timeout_cycles) begin
			$display("timeout after %0d cycles, the table did not complete", cycle_count);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		build_table();
		timeout_cycles = 10 + 3 * entries.size() + 20;
		repeat (9) @(negedge clk);
		// an instruction strobed in the last reset cycle must leave no trace.
		instr_valid = 1'b1;
		instr = encode_imm(ADDI, 20, 0, 'h1111);
		@(negedge clk);
		reset = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		check_flag("result_valid", result_valid, 1'b0);
		check_word("result", result, '0);
		// each entry is checked in the same cycle that issues the next one.
		for (int i = 0; i <= entries.size(); i++) begin
			@(negedge clk);
			if (i > 0) begin
				check_entry(i - 1);
			end
			if (i < entries.size()) begin
				instr_valid = 1'b1;
				instr = entries[i].instr;
			end else begin
				instr_valid = 1'b0;
				instr = '0;
			end
		end
		@(negedge clk);
		cur_entry = -1;
		check_flag("result_valid", result_valid, 1'b0);
		check_flag("illegal", illegal, 1'b0); // the idle word decodes as an illegal opcode.
		$display("errors: %0d value mismatches, %0d missing results", value_errors,
			protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/clock_gen.sv */
`default_nettype none

module clock_gen (
	output logic clk
);

	timeunit 1ns;
	timeprecision 1ps;

	initial clk = 1'b0;

	always #10 clk = ~clk; // 20 ns period.

endmodule

`default_nettype wire

/* rtl/exec_core.sv */
`default_nettype none

module exec_core import exec_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  instr_valid,
	input  word_t instr,
	output logic  result_valid,
	output word_t result,
	output logic  overflow,
	output logic  illegal
);

	opcode_t  opcode;
	sub_op_t  sub_op;
	reg_idx_t rt;
	reg_idx_t ra;
	reg_idx_t rb;
	word_t    imm;
	word_t    reg_a;
	word_t    reg_b;
	word_t    src2;
	word_t    alu_result;
	logic     use_imm;
	logic     write_back;
	logic     dec_illegal;
	logic     alu_overflow;
	logic     reg_we;

	instr_decoder u_decoder (
		.instr      (instr),
		.opcode     (opcode),
		.sub_op     (sub_op),
		.rt         (rt),
		.ra         (ra),
		.rb         (rb),
		.imm        (imm),
		.use_imm    (use_imm),
		.write_back (write_back),
		.illegal    (dec_illegal)
	);

	// the result is written back at the same edge that captures it.
	assign reg_we = instr_valid & write_back;
	assign src2 = use_imm ? imm : reg_b;

	register_file u_regs (
		.clk         (clk),
		.reset       (reset),
		.read_addr_a (ra),
		.read_addr_b (rb),
		.read_data_a (reg_a),
		.read_data_b (reg_b),
		.write_en    (reg_we),
		.write_addr  (rt),
		.write_data  (alu_result)
	);

	alu u_alu (
		.alu_src1     (reg_a),
		.alu_src2     (src2),
		.opcode       (opcode),
		.sub_op_base  (sub_op),
		.alu_result   (alu_result),
		.alu_overflow (alu_overflow)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			result <= '0;
			overflow <= 1'b0;
			illegal <= 1'b0;
		end else begin
			result_valid <= instr_valid;
			result <= instr_valid ? alu_result : '0; // outputs last one cycle only.
			overflow <= instr_valid & alu_overflow;
			illegal <= instr_valid & dec_illegal;
		end
	end

endmodule

`default_nettype wire

/* rtl/alu.sv */
`default_nettype none

`include "exec_config.svh"

module alu import exec_pkg::*; (
	input  word_t   alu_src1,
	input  word_t   alu_src2,
	input  opcode_t opcode,
	input  sub_op_t sub_op_base,
	output word_t   alu_result,
	output logic    alu_overflow
);

	localparam int MSB = `DATA_WIDTH - 1;
	localparam int SHW = $clog2(`DATA_WIDTH);

	// adds in two pieces so the carries into and out of the top bit are both visible.
	// the top bit of the return value is the overflow, the rest is the sum.
	function automatic logic [`DATA_WIDTH:0] add_split(
		input word_t x,
		input word_t y,
		input logic  cin
	);
		logic [MSB-1:0] low;
		logic c_into_msb;
		logic c_out_msb;
		logic s_msb;
		{c_into_msb, low} = {1'b0, x[MSB-1:0]} + {1'b0, y[MSB-1:0]} + {{MSB{1'b0}}, cin};
		{c_out_msb, s_msb} = {1'b0, x[MSB]} + {1'b0, y[MSB]} + {1'b0, c_into_msb};
		return {c_into_msb ^ c_out_msb, s_msb, low};
	endfunction

	logic [`DATA_WIDTH:0] sum;
	logic [`DATA_WIDTH:0] diff;
	logic [`DATA_WIDTH:0] rdiff;
	logic [SHW-1:0] shamt;
	logic [2*`DATA_WIDTH-1:0] rotate;

	assign sum = add_split(alu_src1, alu_src2, 1'b0);
	assign diff = add_split(alu_src1, ~alu_src2, 1'b1); // src1 minus src2.
	assign rdiff = add_split(alu_src2, ~alu_src1, 1'b1); // reverse subtract for SUBRI.
	assign shamt = alu_src2[SHW-1:0];
	assign rotate = {alu_src1, alu_src1} >> shamt;

	always_comb begin
		alu_result = '0;
		alu_overflow = 1'b0;
		case (opcode)
			TY_BASE: begin
				case (sub_op_base)
					ADD: {alu_overflow, alu_result} = sum;
					SUB: {alu_overflow, alu_result} = diff;
					AND: alu_result = alu_src1 & alu_src2;
					OR: alu_result = alu_src1 | alu_src2;
					XOR: alu_result = alu_src1 ^ alu_src2;
					SLT: alu_result = {{MSB{1'b0}}, (alu_src1 < alu_src2)};
					SLTS: alu_result = {{MSB{1'b0}}, ($signed(alu_src1) < $signed(alu_src2))};
					SLL, SLLI: alu_result = alu_src1 << shamt;
					SRL, SRLI: alu_result = alu_src1 >> shamt;
					ROTRI: alu_result = rotate[MSB:0]; // low half of the doubled word.
					default: alu_result = '0;
				endcase
			end
			ADDI, LWI, SWI, LWIBI, SWIBI, TY_LS: begin
				{alu_overflow, alu_result} = sum;
			end
			SUBRI: {alu_overflow, alu_result} = rdiff;
			ANDI: alu_result = alu_src1 & alu_src2;
			ORI: alu_result = alu_src1 | alu_src2;
			XORI: alu_result = alu_src1 ^ alu_src2;
			default: alu_result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/register_file.sv */
`default_nettype none

`include "exec_config.svh"

module register_file import exec_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  reg_idx_t read_addr_a,
	input  reg_idx_t read_addr_b,
	output word_t    read_data_a,
	output word_t    read_data_b,
	input  logic     write_en,
	input  reg_idx_t write_addr,
	input  word_t    write_data
);

	word_t regs [`REG_COUNT];

	// register 0 is hardwired to zero on both ports.
	assign read_data_a = (read_addr_a == '0) ? '0 : regs[read_addr_a];
	assign read_data_b = (read_addr_b == '0) ? '0 : regs[read_addr_b];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en && (write_addr != '0)) begin
			regs[write_addr] <= write_data;
		end
	end

endmodule

`default_nettype wire

/* rtl/instr_decoder.sv */
`default_nettype none

`include "exec_config.svh"

module instr_decoder import exec_pkg::*; (
	input  word_t    instr,
	output opcode_t  opcode,
	output sub_op_t  sub_op,
	output reg_idx_t rt,
	output reg_idx_t ra,
	output reg_idx_t rb,
	output word_t    imm,
	output logic     use_imm,
	output logic     write_back,
	output logic     illegal
);

	word_t simm;
	word_t zimm;
	word_t shimm;

	assign opcode = opcode_t'(instr[30:25]);
	assign sub_op = sub_op_t'(instr[4:0]);
	assign rt = instr[24:20];
	assign ra = instr[19:15];
	assign rb = instr[14:10];

	assign simm = {{(`DATA_WIDTH-15){instr[14]}}, instr[14:0]}; // arithmetic and address offsets.
	assign zimm = {{(`DATA_WIDTH-15){1'b0}}, instr[14:0]};
	assign shimm = {{(`DATA_WIDTH-5){1'b0}}, instr[14:10]}; // shift amount sits in the rb field.

	always_comb begin
		imm = '0;
		use_imm = 1'b0;
		write_back = 1'b0;
		illegal = 1'b0;
		case (opcode)
			TY_BASE: begin
				write_back = 1'b1;
				case (sub_op)
					ADD, SUB, AND, XOR, OR, SLT, SLTS, SLL, SRL: begin
						use_imm = 1'b0; // both operands come from registers.
					end
					SLLI, SRLI, ROTRI: begin
						use_imm = 1'b1;
						imm = shimm;
					end
					default: begin
						illegal = 1'b1;
						write_back = 1'b0;
					end
				endcase
			end
			ADDI, SUBRI: begin
				use_imm = 1'b1;
				write_back = 1'b1;
				imm = simm;
			end
			ANDI, ORI, XORI: begin
				use_imm = 1'b1;
				write_back = 1'b1;
				imm = zimm;
			end
			LWI, SWI, LWIBI, SWIBI: begin
				use_imm = 1'b1; // only the address is produced here.
				imm = simm;
			end
			TY_LS: begin
				use_imm = 1'b0;
			end
			default: begin
				illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

/* rtl/exec_pkg.sv */
`default_nettype none

`include "exec_config.svh"

package exec_pkg;

	typedef logic [`DATA_WIDTH-1:0] word_t;

	typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

	// major opcodes, bits 30 to 25 of the instruction word.
	typedef enum logic [5:0] {
		LWI     = 6'h02,
		LWIBI   = 6'h06,
		SWI     = 6'h0A,
		SWIBI   = 6'h0E,
		TY_LS   = 6'h1C, // register plus register address form.
		TY_BASE = 6'h20, // operation picked by the sub-op field.
		ADDI    = 6'h28,
		SUBRI   = 6'h29,
		ANDI    = 6'h2A,
		XORI    = 6'h2B,
		ORI     = 6'h2C
	} opcode_t;

	// sub-operations of TY_BASE, bits 4 to 0 of the instruction word.
	typedef enum logic [4:0] {
		ADD   = 5'd0,
		SUB   = 5'd1,
		AND   = 5'd2,
		XOR   = 5'd3,
		OR    = 5'd4,
		SLT   = 5'd6,
		SLTS  = 5'd7,
		SLLI  = 5'd8,
		SRLI  = 5'd9,
		ROTRI = 5'd11,
		SLL   = 5'd12,
		SRL   = 5'd13
	} sub_op_t;

endpackage

`default_nettype wire

/* rtl/exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Width of one data word and of every ALU operand.
`define DATA_WIDTH 32

// Number of general registers in the register file.
`define REG_COUNT 32

// Width of a register index in the instruction word.
`define REG_ADDR_W 5

`endif
